// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Primary opcodes
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LH      = 6'h21,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_LHU     = 6'h25,
        OP_SB      = 6'h28,
        OP_SH      = 6'h29,
        OP_SW      = 6'h2b
    } opcode_e;

    // Function field of SPECIAL instructions
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_WORD,
        MEM_HALF,
        MEM_BYTE
    } mem_size_e;

    // Return address register of jal
    localparam reg_idx_t   link_reg = 5'd31;
    localparam logic [3:0] lane_all = 4'b1111;

endpackage

// ==== logic/stage_ifs.sv ====
// Decode to execute payload
interface ex_bus_if import cpu_pkg::*; ();
    word_t      operand_a, operand_b;
    word_t      imm;
    logic [4:0] shamt;
    alu_op_e    alu_op;
    logic       use_imm, use_shamt;
    reg_idx_t   dest;
    logic       reg_write;
    logic       is_link;
    word_t      link_addr;
    logic       mem_read, mem_write;
    mem_size_e  mem_size;
    logic       mem_signed;

    modport src (output operand_a, operand_b, imm, shamt, alu_op, use_imm, use_shamt,
                 dest, reg_write, is_link, link_addr, mem_read, mem_write, mem_size,
                 mem_signed);
    modport dst (input operand_a, operand_b, imm, shamt, alu_op, use_imm, use_shamt,
                 dest, reg_write, is_link, link_addr, mem_read, mem_write, mem_size,
                 mem_signed);
endinterface

// Execute to memory payload
interface mem_bus_if import cpu_pkg::*; ();
    word_t     result, store_data;
    reg_idx_t  dest;
    logic      reg_write;
    logic      mem_read, mem_write;
    mem_size_e mem_size;
    logic      mem_signed;

    modport src (output result, store_data, dest, reg_write, mem_read, mem_write,
                 mem_size, mem_signed);
    modport dst (input result, store_data, dest, reg_write, mem_read, mem_write,
                 mem_size, mem_signed);
endinterface

// Results flowing back to decode
interface fwd_if import cpu_pkg::*; ();
    reg_idx_t ex_dest, mem_dest, wb_dest;
    logic     ex_write, mem_write, wb_write;
    logic     ex_load;
    word_t    ex_value, mem_value, wb_value;

    modport ex   (output ex_dest, ex_write, ex_load, ex_value);
    modport mem  (output mem_dest, mem_write, mem_value, wb_dest, wb_write, wb_value);
    modport sink (input ex_dest, ex_write, ex_load, ex_value, mem_dest, mem_write,
                  mem_value, wb_dest, wb_write, wb_value);
endinterface

// ==== logic/instr_fetch.sv ====
module instr_fetch import cpu_pkg::*; #(
    parameter word_t reset_addr = '0
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  stall,
    input  logic  redirect,
    input  word_t target,
    input  word_t inst,
    output word_t pcaddr,
    output word_t id_inst,
    output word_t id_pc_plus4
);

    word_t pc;
    word_t pc_plus4;

    assign pc_plus4 = pc + 32'd4;
    assign pcaddr   = pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= reset_addr;
        end else if (!stall) begin
            pc <= redirect ? target : pc_plus4;
        end
    end

    // Fetch/decode register
    // Reset loads sll r0 as a no-op
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_inst     <= '0;
            id_pc_plus4 <= '0;
        end else if (!stall) begin
            id_inst     <= inst;
            id_pc_plus4 <= pc_plus4;
        end
    end

    // Fetch addresses stay word aligned
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// ==== logic/reg_file.sv ====
module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rs_data,
    output word_t    rt_data,
    input  reg_idx_t wb_dest,
    input  logic     wb_write,
    input  word_t    wb_value
);

    word_t regs [32];

    // Same-cycle write-back is visible to the reader
    assign rs_data = (rs_idx == '0) ? '0 :
                     (wb_write && wb_dest == rs_idx) ? wb_value : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 :
                     (wb_write && wb_dest == rt_idx) ? wb_value : regs[rt_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write && wb_dest != '0) begin
            regs[wb_dest] <= wb_value;
        end
    end

endmodule

// ==== logic/decode_stage.sv ====
module decode_stage import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t id_inst,
    input  word_t id_pc_plus4,
    output logic  stall,
    output logic  redirect,
    output word_t target,
    ex_bus_if.src ex,
    fwd_if.sink   fwd
);

    opcode_e     op;
    funct_e      fn;
    reg_idx_t    rs, rt, rd, dest;
    logic [15:0] imm16;
    word_t       rs_data, rt_data;
    word_t       operand_a, operand_b, imm_ext;
    alu_op_e     alu_op;
    logic        use_imm, use_shamt, sign_ext, is_lui, dest_rt, reg_write;
    logic        mem_read, mem_write, mem_signed, is_link;
    mem_size_e   mem_size;
    logic        is_beq, is_bne, is_jump, is_jr, is_ctrl, taken;
    logic        ex_hit_a, ex_hit_b, mem_hit_a, mem_hit_b;

    assign op    = opcode_e'(id_inst[31:26]);
    assign fn    = funct_e'(id_inst[5:0]);
    assign rs    = id_inst[25:21];
    assign rt    = id_inst[20:16];
    assign rd    = id_inst[15:11];
    assign imm16 = id_inst[15:0];

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        use_shamt = 1'b0;
        sign_ext  = 1'b0;
        is_lui    = 1'b0;
        dest_rt   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_link   = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_jump   = 1'b0;
        is_jr     = 1'b0;
        case (op)
            OP_SPECIAL: begin
                reg_write = 1'b1;
                use_shamt = (fn == FN_SLL) || (fn == FN_SRL) || (fn == FN_SRA);
                case (fn)
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_JR: begin
                        is_jr     = 1'b1;
                        reg_write = 1'b0;
                    end
                    default: reg_write = 1'b0;
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                use_imm   = 1'b1;
                dest_rt   = 1'b1;
                reg_write = 1'b1;
                sign_ext  = (op == OP_ADDIU) || (op == OP_SLTI);
                is_lui    = (op == OP_LUI);
                case (op)
                    OP_SLTI: alu_op = ALU_SLT;
                    OP_ANDI: alu_op = ALU_AND;
                    OP_ORI:  alu_op = ALU_OR;
                    OP_XORI: alu_op = ALU_XOR;
                    OP_LUI:  alu_op = ALU_PASS_B;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                use_imm   = 1'b1;
                sign_ext  = 1'b1;
                dest_rt   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            OP_SB, OP_SH, OP_SW: begin
                use_imm   = 1'b1;
                sign_ext  = 1'b1;
                mem_write = 1'b1;
            end
            OP_BEQ: is_beq = 1'b1;
            OP_BNE: is_bne = 1'b1;
            OP_J:   is_jump = 1'b1;
            OP_JAL: begin
                is_jump   = 1'b1;
                is_link   = 1'b1;
                reg_write = 1'b1;
            end
            // Anything else runs as a no-op
            default: ;
        endcase
    end

    always_comb begin
        case (op)
            OP_LB, OP_LBU, OP_SB: mem_size = MEM_BYTE;
            OP_LH, OP_LHU, OP_SH: mem_size = MEM_HALF;
            default:              mem_size = MEM_WORD;
        endcase
    end

    assign mem_signed = (op == OP_LB) || (op == OP_LH);
    assign imm_ext    = is_lui ? {imm16, 16'h0000} : {{16{sign_ext & imm16[15]}}, imm16};
    assign dest       = dest_rt ? rt : rd;

    //////////////////////////////////////////////////////////////////////
    // Operands and hazards
    //////////////////////////////////////////////////////////////////////

    reg_file reg_file_i (
        .clk     (clk),
        .rst     (rst),
        .rs_idx  (rs),
        .rt_idx  (rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb_dest (fwd.wb_dest),
        .wb_write(fwd.wb_write),
        .wb_value(fwd.wb_value)
    );

    assign ex_hit_a  = (rs != '0) && fwd.ex_write && (fwd.ex_dest == rs);
    assign ex_hit_b  = (rt != '0) && fwd.ex_write && (fwd.ex_dest == rt);
    assign mem_hit_a = (rs != '0) && fwd.mem_write && (fwd.mem_dest == rs);
    assign mem_hit_b = (rt != '0) && fwd.mem_write && (fwd.mem_dest == rt);

    // Youngest producer wins
    assign operand_a = ex_hit_a ? fwd.ex_value : (mem_hit_a ? fwd.mem_value : rs_data);
    assign operand_b = ex_hit_b ? fwd.ex_value : (mem_hit_b ? fwd.mem_value : rt_data);

    // Load data is not ready until the load reaches memory
    assign stall = fwd.ex_load && (ex_hit_a || ex_hit_b);

    // Branches and jumps resolve here
    assign is_ctrl = is_beq || is_bne || is_jump || is_jr;
    assign taken = is_jump || is_jr || (is_beq && operand_a == operand_b) ||
                   (is_bne && operand_a != operand_b);
    assign redirect = taken && !stall;
    assign target = is_jr   ? operand_a :
                    is_jump ? {id_pc_plus4[31:28], id_inst[25:0], 2'b00} :
                    id_pc_plus4 + {{14{imm16[15]}}, imm16, 2'b00};

    //////////////////////////////////////////////////////////////////////
    // Decode/execute register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex.reg_write <= 1'b0;
            ex.mem_read  <= 1'b0;
            ex.mem_write <= 1'b0;
        end else begin
            ex.reg_write <= reg_write && !stall;
            ex.mem_read  <= mem_read && !stall;
            ex.mem_write <= mem_write && !stall;
        end
    end

    always_ff @(posedge clk) begin
        ex.operand_a  <= operand_a;
        ex.operand_b  <= operand_b;
        ex.imm        <= imm_ext;
        ex.shamt      <= id_inst[10:6];
        ex.alu_op     <= alu_op;
        ex.use_imm    <= use_imm;
        ex.use_shamt  <= use_shamt;
        ex.dest       <= dest;
        ex.is_link    <= is_link;
        ex.link_addr  <= id_pc_plus4 + 32'd4;
        ex.mem_size   <= mem_size;
        ex.mem_signed <= mem_signed;
    end

    // No branch or jump sits in the delay slot of another
    assert property (@(posedge clk) disable iff (rst) (is_ctrl && !stall) |=> !is_ctrl);

endmodule

// ==== logic/execute_stage.sv ====
module execute_stage import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    ex_bus_if.dst  ex,
    mem_bus_if.src mem,
    fwd_if.ex      fwd
);

    word_t    alu_a, alu_b, alu_out, result;
    reg_idx_t dest;

    // Shifts take their amount from the instruction
    assign alu_a = ex.use_shamt ? {27'b0, ex.shamt} : ex.operand_a;
    assign alu_b = ex.use_imm ? ex.imm : ex.operand_b;

    always_comb begin
        case (ex.alu_op)
            ALU_ADD:    alu_out = alu_a + alu_b;
            ALU_SUB:    alu_out = alu_a - alu_b;
            ALU_AND:    alu_out = alu_a & alu_b;
            ALU_OR:     alu_out = alu_a | alu_b;
            ALU_XOR:    alu_out = alu_a ^ alu_b;
            ALU_NOR:    alu_out = ~(alu_a | alu_b);
            ALU_SLT:    alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU:   alu_out = {31'b0, alu_a < alu_b};
            ALU_SLL:    alu_out = alu_b << alu_a[4:0];
            ALU_SRL:    alu_out = alu_b >> alu_a[4:0];
            ALU_SRA:    alu_out = $signed(alu_b) >>> alu_a[4:0];
            ALU_PASS_B: alu_out = alu_b;
            default:    alu_out = '0;
        endcase
    end

    // jal writes the return address to r31
    assign result = ex.is_link ? ex.link_addr : alu_out;
    assign dest   = ex.is_link ? link_reg : ex.dest;

    assign fwd.ex_dest  = dest;
    assign fwd.ex_write = ex.reg_write;
    assign fwd.ex_load  = ex.mem_read;
    assign fwd.ex_value = result;

    //////////////////////////////////////////////////////////////////////
    // Execute/memory register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem.reg_write <= 1'b0;
            mem.mem_read  <= 1'b0;
            mem.mem_write <= 1'b0;
        end else begin
            mem.reg_write <= ex.reg_write;
            mem.mem_read  <= ex.mem_read;
            mem.mem_write <= ex.mem_write;
        end
    end

    always_ff @(posedge clk) begin
        mem.result     <= result;
        mem.store_data <= ex.operand_b;
        mem.dest       <= dest;
        mem.mem_size   <= ex.mem_size;
        mem.mem_signed <= ex.mem_signed;
    end

endmodule

// ==== logic/result_stage.sv ====
module result_stage import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    mem_bus_if.dst     mem,
    fwd_if.mem         fwd,
    input  word_t      datain,
    output word_t      dataout,
    output word_t      dataaddr,
    output logic       memread,
    output logic [3:0] memwrite
);

    logic [1:0]  offset;
    logic [3:0]  lanes;
    logic [7:0]  load_byte;
    logic [15:0] load_half;
    word_t       load_data;

    assign dataaddr = mem.result;
    assign offset   = mem.result[1:0];
    assign memread  = mem.mem_read;

    //////////////////////////////////////////////////////////////////////
    // Stores
    //////////////////////////////////////////////////////////////////////

    // Lane 3 holds the byte at offset 0
    always_comb begin
        case (mem.mem_size)
            MEM_BYTE: begin
                dataout = {4{mem.store_data[7:0]}};
                lanes   = 4'b1000 >> offset;
            end
            MEM_HALF: begin
                dataout = {2{mem.store_data[15:0]}};
                lanes   = offset[1] ? 4'b0011 : 4'b1100;
            end
            default: begin
                dataout = mem.store_data;
                lanes   = lane_all;
            end
        endcase
    end

    assign memwrite = mem.mem_write ? lanes : 4'b0000;

    //////////////////////////////////////////////////////////////////////
    // Loads
    //////////////////////////////////////////////////////////////////////

    assign load_byte = datain[(3 - offset) * 8 +: 8];
    assign load_half = offset[1] ? datain[15:0] : datain[31:16];

    always_comb begin
        case (mem.mem_size)
            MEM_BYTE: load_data = {{24{mem.mem_signed & load_byte[7]}}, load_byte};
            MEM_HALF: load_data = {{16{mem.mem_signed & load_half[15]}}, load_half};
            default:  load_data = datain;
        endcase
    end

    assign fwd.mem_dest  = mem.dest;
    assign fwd.mem_write = mem.reg_write;
    assign fwd.mem_value = mem.mem_read ? load_data : mem.result;

    // Memory/write-back register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fwd.wb_write <= 1'b0;
        end else begin
            fwd.wb_write <= mem.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        fwd.wb_dest  <= mem.dest;
        fwd.wb_value <= fwd.mem_value;
    end

    // Address from execute must suit the access size
    assert property (@(posedge clk) disable iff (rst)
        (mem.mem_read || mem.mem_write) |->
            (mem.mem_size != MEM_HALF || !offset[0]) &&
            (mem.mem_size != MEM_WORD || offset == 2'b00));

endmodule

// ==== logic/pipelined_cpu.sv ====
module pipelined_cpu import cpu_pkg::*; #(
    parameter word_t reset_addr = '0
) (
    input  logic       clk,
    input  logic       rst,
    output word_t      pcaddr,
    input  word_t      inst,
    input  word_t      datain,
    output word_t      dataout,
    output word_t      dataaddr,
    output logic       memread,
    output logic [3:0] memwrite
);

    logic  stall;
    logic  redirect;
    word_t target;
    word_t id_inst;
    word_t id_pc_plus4;

    ex_bus_if  ex_bus ();
    mem_bus_if mem_bus ();
    fwd_if     fwd_bus ();

    instr_fetch #(
        .reset_addr(reset_addr)
    ) instr_fetch_i (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .redirect   (redirect),
        .target     (target),
        .inst       (inst),
        .pcaddr     (pcaddr),
        .id_inst    (id_inst),
        .id_pc_plus4(id_pc_plus4)
    );

    decode_stage decode_stage_i (
        .clk        (clk),
        .rst        (rst),
        .id_inst    (id_inst),
        .id_pc_plus4(id_pc_plus4),
        .stall      (stall),
        .redirect   (redirect),
        .target     (target),
        .ex         (ex_bus),
        .fwd        (fwd_bus)
    );

    execute_stage execute_stage_i (
        .clk(clk),
        .rst(rst),
        .ex (ex_bus),
        .mem(mem_bus),
        .fwd(fwd_bus)
    );

    result_stage result_stage_i (
        .clk     (clk),
        .rst     (rst),
        .mem     (mem_bus),
        .fwd     (fwd_bus),
        .datain  (datain),
        .dataout (dataout),
        .dataaddr(dataaddr),
        .memread (memread),
        .memwrite(memwrite)
    );

endmodule

// ==== bench/ref_model.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// Instruction encoders
function automatic word_t rtype(funct_e fn, int rd, int rs, int rt, int sh);
    return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
endfunction

function automatic word_t itype(opcode_e op, int rt, int rs, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic word_t jtype(opcode_e op, int idx);
    return {op, 26'(idx)};
endfunction

// Appends one expected store and applies it to the model memory
function automatic void log_store(word_t addr, logic [3:0] mask, word_t data);
    exp_addr.push_back(addr);
    exp_mask.push_back(mask);
    exp_data.push_back(data);
    for (int l = 0; l < 4; l++) begin
        if (mask[l]) ref_dmem[addr[7:2]][8*l +: 8] = data[8*l +: 8];
    end
endfunction

//////////////////////////////////////////////////////////////////////
// Instruction-set model that returns the executed instruction count
//////////////////////////////////////////////////////////////////////
function automatic int run_reference();
    word_t      r [32];
    word_t      pc, npc, nxt, w, a, b, se, ze, addr, v, sh_byte;
    logic [5:0] op, fn;
    logic [4:0] rs, rt, rd, sh;
    logic [1:0] off;
    logic [15:0] half;
    int         steps;
    for (int i = 0; i < 32; i++) r[i] = '0;
    pc = '0;
    npc = 32'd4;
    steps = 0;
    while (steps < 1000) begin
        w = imem[pc[9:2]];
        // The closing loop is a jump to itself
        if (w[31:26] == OP_J && {npc[31:28], w[25:0], 2'b00} == pc) break;
        steps++;
        nxt = npc + 32'd4;
        op = w[31:26];
        fn = w[5:0];
        rs = w[25:21];
        rt = w[20:16];
        rd = w[15:11];
        sh = w[10:6];
        a = r[rs];
        b = r[rt];
        se = {{16{w[15]}}, w[15:0]};
        ze = {16'h0000, w[15:0]};
        addr = a + se;
        off = addr[1:0];
        v = ref_dmem[addr[7:2]];
        sh_byte = v >> (5'd24 - {off, 3'b000});
        half = (off == 2'b00) ? v[31:16] : v[15:0];
        case (op)
            OP_SPECIAL: case (fn)
                FN_SLL:  r[rd] = b << sh;
                FN_SRL:  r[rd] = b >> sh;
                FN_SRA:  r[rd] = $signed(b) >>> sh;
                FN_JR:   nxt = a;
                FN_ADDU: r[rd] = a + b;
                FN_SUBU: r[rd] = a - b;
                FN_AND:  r[rd] = a & b;
                FN_OR:   r[rd] = a | b;
                FN_XOR:  r[rd] = a ^ b;
                FN_NOR:  r[rd] = ~(a | b);
                FN_SLT:  r[rd] = {31'b0, $signed(a) < $signed(b)};
                FN_SLTU: r[rd] = {31'b0, a < b};
                default: ;
            endcase
            OP_J:     nxt = {npc[31:28], w[25:0], 2'b00};
            OP_JAL: begin
                r[31] = pc + 32'd8;
                nxt = {npc[31:28], w[25:0], 2'b00};
            end
            OP_BEQ:   if (a == b) nxt = npc + (se << 2);
            OP_BNE:   if (a != b) nxt = npc + (se << 2);
            OP_ADDIU: r[rt] = a + se;
            OP_SLTI:  r[rt] = {31'b0, $signed(a) < $signed(se)};
            OP_ANDI:  r[rt] = a & ze;
            OP_ORI:   r[rt] = a | ze;
            OP_XORI:  r[rt] = a ^ ze;
            OP_LUI:   r[rt] = {w[15:0], 16'h0000};
            OP_LB:    r[rt] = {{24{sh_byte[7]}}, sh_byte[7:0]};
            OP_LBU:   r[rt] = {24'h0, sh_byte[7:0]};
            OP_LH:    r[rt] = {{16{half[15]}}, half};
            OP_LHU:   r[rt] = {16'h0, half};
            OP_LW:    r[rt] = v;
            OP_SB:    log_store(addr, 4'b0001 << (2'd3 - off), {4{b[7:0]}});
            OP_SH:    log_store(addr, (off == 2'b00) ? 4'b1100 : 4'b0011, {2{b[15:0]}});
            OP_SW:    log_store(addr, lane_all, b);
            default: ;
        endcase
        r[0] = '0;
        pc = npc;
        npc = nxt;
    end
    return steps;
endfunction

`endif

// ==== bench/cpu_tb.sv ====
module cpu_tb import cpu_pkg::*; ();

    logic       clk;
    logic       rst;
    word_t      pcaddr, inst, datain, dataout, dataaddr;
    logic       memread;
    logic [3:0] memwrite;

    word_t imem [256];
    word_t dmem [64];
    word_t ref_dmem [64];
    word_t exp_addr [$];
    logic [3:0] exp_mask [$];
    word_t exp_data [$];
    int    exp_idx = 0;
    int    n = 0;
    int    slot = 32'h40;
    int    seed = 32'hfb7cc5c1;
    int    steps, limit, cycles;

    `include "ref_model.svh"

    pipelined_cpu #(.reset_addr('0)) pipelined_cpu_i (
        .clk(clk), .rst(rst), .pcaddr(pcaddr), .inst(inst), .datain(datain),
        .dataout(dataout), .dataaddr(dataaddr), .memread(memread), .memwrite(memwrite)
    );

    assign inst   = imem[pcaddr[9:2]];
    assign datain = dmem[dataaddr[7:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        for (int l = 0; l < 4; l++) begin
            if (memwrite[l]) dmem[dataaddr[7:2]][8*l +: 8] <= dataout[8*l +: 8];
        end
    end

    task automatic report_failure(string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic emit(word_t w);
        imem[n] = w;
        n++;
    endtask

    // Stores a register to the next free result slot
    task automatic save_reg(int rg);
        emit(itype(OP_SW, rg, 0, slot));
        slot += 4;
    endtask

    task automatic build_program();
        for (int i = 0; i < 256; i++) imem[i] = '0;
        for (int i = 0; i < 64; i++) begin
            ref_dmem[i] = $random(seed);
            dmem[i] <= ref_dmem[i];
        end
        emit(itype(OP_ADDIU, 1, 0, $random(seed)));
        emit(itype(OP_ADDIU, 2, 0, $random(seed)));
        emit(rtype(FN_ADDU, 3, 1, 2, 0));
        emit(rtype(FN_SUBU, 4, 3, 1, 0));
        emit(rtype(FN_XOR, 5, 4, 2, 0));
        emit(32'h0);
        emit(rtype(FN_NOR, 6, 5, 3, 0));
        emit(rtype(FN_SLT, 7, 6, 1, 0));
        emit(rtype(FN_SLTU, 8, 6, 1, 0));
        emit(rtype(FN_SLL, 9, 0, 3, 5));
        emit(rtype(FN_SRL, 10, 0, 6, 3));
        emit(rtype(FN_SRA, 11, 0, 6, 7));
        emit(itype(OP_ANDI, 12, 6, $random(seed)));
        emit(itype(OP_ORI, 13, 5, $random(seed)));
        emit(itype(OP_XORI, 14, 13, $random(seed)));
        emit(itype(OP_LUI, 15, 0, $random(seed)));
        emit(itype(OP_SLTI, 16, 15, $random(seed)));
        for (int rg = 3; rg <= 16; rg++) save_reg(rg);
        // Load-use pairs
        emit(itype(OP_LW, 17, 0, 32'h04));
        emit(rtype(FN_ADDU, 18, 17, 1, 0));
        save_reg(18);
        emit(itype(OP_LB, 19, 0, 32'h09));
        save_reg(19);
        emit(itype(OP_LBU, 20, 0, 32'h0a));
        save_reg(20);
        emit(itype(OP_LH, 21, 0, 32'h0e));
        save_reg(21);
        emit(itype(OP_LHU, 22, 0, 32'h10));
        save_reg(22);
        // Byte and half stores at every legal offset
        for (int o = 0; o < 4; o++) emit(itype(OP_SB, 3 + o, 0, 32'hf0 + o));
        emit(itype(OP_SH, 4, 0, 32'hf4));
        emit(itype(OP_SH, 5, 0, 32'hf6));
        emit(itype(OP_LBU, 23, 0, 32'hf1));
        save_reg(23);
        emit(itype(OP_LH, 25, 0, 32'hf6));
        save_reg(25);
        ////////////////////////////////////////////////////////////////
        // Branches and jumps with a store in each delay slot
        ////////////////////////////////////////////////////////////////
        emit(itype(OP_ADDIU, 24, 0, 5));
        emit(itype(OP_BEQ, 24, 24, 2));
        save_reg(1);
        save_reg(2);
        emit(itype(OP_BNE, 24, 24, 2));
        save_reg(3);
        save_reg(4);
        emit(itype(OP_BEQ, 0, 24, 2));
        save_reg(5);
        save_reg(6);
        emit(itype(OP_BNE, 0, 24, 2));
        save_reg(7);
        save_reg(8);
        emit(jtype(OP_J, n + 3));
        save_reg(9);
        save_reg(10);
        emit(jtype(OP_JAL, 200));
        save_reg(11);
        save_reg(12);
        emit(jtype(OP_J, n));
        emit(32'h0);
        // Subroutine saves the link value and returns
        n = 200;
        save_reg(31);
        emit(rtype(FN_JR, 0, 31, 0, 0));
        save_reg(13);
    endtask

    // Compares every store cycle with the next expected store
    always @(negedge clk) begin
        if (!rst && memwrite != 4'b0000) begin
            assert (exp_idx < exp_addr.size())
                else report_failure("A store appeared after the last expected one");
            assert (dataaddr == exp_addr[exp_idx])
                else report_failure($sformatf("FAILED dataaddr: got %h expected %h",
                                              dataaddr, exp_addr[exp_idx]));
            assert (memwrite == exp_mask[exp_idx])
                else report_failure($sformatf("FAILED memwrite: got %h expected %h",
                                              memwrite, exp_mask[exp_idx]));
            assert (dataout == exp_data[exp_idx])
                else report_failure($sformatf("FAILED dataout: got %h expected %h",
                                              dataout, exp_data[exp_idx]));
            exp_idx++;
        end
    end

    initial begin
        rst = 1'b1;
        build_program();
        steps = run_reference();
        limit = 2 * steps + 64;
        for (int c = 0; c <= 16; c++) begin
            if (c < 16) @(negedge clk);
            else rst = 1'b0;
            assert (memread == 1'b0 && memwrite == 4'b0000 && pcaddr == '0)
                else report_failure($sformatf(
                    "FAILED reset state: pcaddr %h memread %h memwrite %h",
                    pcaddr, memread, memwrite));
        end
        cycles = 0;
        while (exp_idx < exp_addr.size() && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_idx < exp_addr.size()) begin
            report_failure("Timeout: the expected stores did not complete");
        end else begin
            // A few more cycles catch any extra store
            repeat (8) @(negedge clk);
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== project.f ====
+incdir+bench
logic/cpu_pkg.sv
logic/stage_ifs.sv
logic/instr_fetch.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/pipelined_cpu.sv
bench/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_BIN   ?= sim_cpu
VFLAGS    ?= --binary --timing --assert

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(SIM_BIN)
	-./$(BUILD_DIR)/$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
